//--- Bender.yml
package:
  name: pwo_unit

sources:
  # Packages first, then the design bottom up
  - files:
      - common/ntt_arith_pkg.sv
      - common/ntt_ctrl_pkg.sv
      - hdl/pwo_delay_line.sv
      - hdl/pwo_ctrl.sv
      - pwo_lane/pwo_mod_mult.sv
      - pwo_lane/pwo_lane.sv
      - hdl/pwo_top.sv

  # Simulation only, top module pwo_tb
  - target: test
    files:
      - verification/pwo_mem_model.sv
      - verification/pwo_tb.sv

//--- build.f
common/ntt_arith_pkg.sv
common/ntt_ctrl_pkg.sv
hdl/pwo_delay_line.sv
hdl/pwo_ctrl.sv
pwo_lane/pwo_mod_mult.sv
pwo_lane/pwo_lane.sv
hdl/pwo_top.sv
verification/pwo_mem_model.sv
verification/pwo_tb.sv

//--- common/ntt_arith_pkg.sv
// Modular arithmetic definitions
`default_nettype none

package ntt_arith_pkg;

    //======================================================================
    // Coefficient and memory word geometry
    //======================================================================

    // One coefficient fits in 23 bits
    localparam int COEFF_WIDTH = 23;

    // Each lane carries a coefficient with a zero top bit
    localparam int LANE_WIDTH = 24;

    localparam int LANES_PER_WORD = 4;

    localparam int MEM_DATA_WIDTH = LANES_PER_WORD * LANE_WIDTH;

    //======================================================================
    // Modulus and reduction constants
    //======================================================================

    // ML-DSA prime q = 2^23 - 2^13 + 1
    localparam logic [LANE_WIDTH-1:0] NTT_Q = 24'd8380417;

    // Barrett scaling by 2^48 keeps the quotient estimate within one of exact
    localparam int BARRETT_SHIFT = 2 * LANE_WIDTH;

    localparam logic [LANE_WIDTH+1:0] BARRETT_MU =
        (LANE_WIDTH + 2)'((64'd1 << BARRETT_SHIFT) / NTT_Q);

    //======================================================================
    // Types
    //======================================================================

    typedef logic [COEFF_WIDTH-1:0] coeff_t;

    // Lane 0 sits in the low bits of the word
    typedef logic [LANES_PER_WORD-1:0][LANE_WIDTH-1:0] mem_word_t;

endpackage

`default_nettype wire

//--- common/ntt_ctrl_pkg.sv
// Pointwise sequencing definitions
`default_nettype none

package ntt_ctrl_pkg;

    // Pointwise operation select
    // Code 2'b11 has no meaning
    typedef enum logic [1:0] {
        pwm = 2'b00,
        pwa = 2'b01,
        pws = 2'b10
    } pwo_mode_t;

    //======================================================================
    // Memory addressing
    //======================================================================

    localparam int MEM_ADDR_WIDTH = 15;

    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;

    // 256 coefficients at four per word
    localparam int POLY_WORDS = 64;

    localparam int WORD_CNT_WIDTH = $clog2(POLY_WORDS);

    //======================================================================
    // Pipeline timing
    //======================================================================

    // Multiply in two stages then one add stage
    localparam int LANE_LATENCY = 3;

endpackage

`default_nettype wire

//--- hdl/pwo_ctrl.sv
// Pointwise operation sequencer
`timescale 1ns/100ps
`default_nettype none

module pwo_ctrl
    import ntt_ctrl_pkg::*;
#(
    parameter int WRITE_DELAY = 5
)
(
    input  wire           clk,
    input  wire           reset_n,
    input  wire           zeroize_i,

    input  wire           start_i,
    input  var pwo_mode_t mode_i,
    input  wire           accumulate_i,
    input  var mem_addr_t a_base_i,
    input  var mem_addr_t b_base_i,
    input  var mem_addr_t c_base_i,

    output logic          a_rd_en_o,
    output mem_addr_t     a_rd_addr_o,
    output logic          b_rd_en_o,
    output mem_addr_t     b_rd_addr_o,
    output logic          c_rd_en_o,
    output mem_addr_t     c_rd_addr_o,

    output pwo_mode_t     mode_o,
    output logic          busy_o,
    output logic          done_o
);

    localparam int DRAIN_CNT_WIDTH = $clog2(WRITE_DELAY + 1);

    logic                       busy_q;
    logic                       issue_q;
    logic                       c_rd_en_q;
    logic                       done_q;
    logic [WORD_CNT_WIDTH-1:0]  word_cnt_q;
    logic [DRAIN_CNT_WIDTH-1:0] drain_cnt_q;
    pwo_mode_t                  mode_q;
    mem_addr_t                  a_addr_q;
    mem_addr_t                  b_addr_q;
    mem_addr_t                  c_addr_q;

    //======================================================================
    // Issue phase walks all words, drain phase waits out the pipeline
    //======================================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q      <= 1'b0;
            issue_q     <= 1'b0;
            c_rd_en_q   <= 1'b0;
            done_q      <= 1'b0;
            word_cnt_q  <= '0;
            drain_cnt_q <= '0;
            mode_q      <= pwm;
            a_addr_q    <= '0;
            b_addr_q    <= '0;
            c_addr_q    <= '0;
        end
        else if (zeroize_i) begin
            busy_q      <= 1'b0;
            issue_q     <= 1'b0;
            c_rd_en_q   <= 1'b0;
            done_q      <= 1'b0;
            word_cnt_q  <= '0;
            drain_cnt_q <= '0;
            mode_q      <= pwm;
            a_addr_q    <= '0;
            b_addr_q    <= '0;
            c_addr_q    <= '0;
        end
        else begin
            done_q <= 1'b0;
            if (start_i && !busy_q) begin
                busy_q      <= 1'b1;
                issue_q     <= 1'b1;
                // Old C is only needed when accumulating products
                c_rd_en_q   <= (mode_i == pwm) && accumulate_i;
                word_cnt_q  <= '0;
                drain_cnt_q <= '0;
                mode_q      <= mode_i;
                a_addr_q    <= a_base_i;
                b_addr_q    <= b_base_i;
                c_addr_q    <= c_base_i;
            end
            else if (issue_q) begin
                a_addr_q   <= a_addr_q + 1'b1;
                b_addr_q   <= b_addr_q + 1'b1;
                c_addr_q   <= c_addr_q + 1'b1;
                word_cnt_q <= word_cnt_q + 1'b1;
                if (word_cnt_q == WORD_CNT_WIDTH'(POLY_WORDS - 1)) begin
                    issue_q   <= 1'b0;
                    c_rd_en_q <= 1'b0;
                end
            end
            else if (busy_q) begin
                drain_cnt_q <= drain_cnt_q + 1'b1;
                if (drain_cnt_q == DRAIN_CNT_WIDTH'(WRITE_DELAY - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    assign a_rd_en_o   = issue_q;
    assign b_rd_en_o   = issue_q;
    assign c_rd_en_o   = c_rd_en_q;
    assign a_rd_addr_o = a_addr_q;
    assign b_rd_addr_o = b_addr_q;
    assign c_rd_addr_o = c_addr_q;
    assign mode_o      = mode_q;
    assign busy_o      = busy_q;
    assign done_o      = done_q;

    // The unused mode code must never be requested by the host
    assert property (@(posedge clk) disable iff (!reset_n)
        start_i |-> mode_i inside {pwm, pwa, pws})
        else $error("start requested with the unused mode code");

endmodule

`default_nettype wire

//--- hdl/pwo_delay_line.sv
// Fixed depth delay line
`timescale 1ns/100ps
`default_nettype none

module pwo_delay_line #(
    parameter int  DEPTH = 1,
    parameter type T     = logic
)
(
    input  wire  clk,
    input  wire  reset_n,
    input  wire  zeroize_i,

    input  var T data_i,
    output T     data_o
);

    // Stage 0 takes the input, stage DEPTH-1 drives the output
    T [DEPTH-1:0] stage_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            stage_q <= '0;
        end
        else if (zeroize_i) begin
            stage_q <= '0;
        end
        else begin
            stage_q[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign data_o = stage_q[DEPTH-1];

endmodule

`default_nettype wire

//--- hdl/pwo_top.sv
// Pointwise operation unit top level
`timescale 1ns/100ps
`default_nettype none

module pwo_top
    import ntt_arith_pkg::*;
    import ntt_ctrl_pkg::*;
#(
    parameter int SRAM_LATENCY = 1
)
(
    input  wire           clk,
    input  wire           reset_n,
    input  wire           zeroize_i,

    input  wire           start_i,
    input  var pwo_mode_t mode_i,
    input  wire           accumulate_i,
    input  var mem_addr_t a_base_i,
    input  var mem_addr_t b_base_i,
    input  var mem_addr_t c_base_i,

    // Operand read ports
    output logic          a_rd_en_o,
    output mem_addr_t     a_rd_addr_o,
    input  var mem_word_t a_rd_data_i,
    input  wire           a_rd_valid_i,
    output logic          b_rd_en_o,
    output mem_addr_t     b_rd_addr_o,
    input  var mem_word_t b_rd_data_i,
    input  wire           b_rd_valid_i,

    // Result memory ports
    output logic          c_rd_en_o,
    output mem_addr_t     c_rd_addr_o,
    input  var mem_word_t c_rd_data_i,
    input  wire           c_rd_valid_i,
    output logic          c_wr_en_o,
    output mem_addr_t     c_wr_addr_o,
    output mem_word_t     c_wr_data_o,

    output logic          busy_o,
    output logic          done_o
);

    // Memory latency, lane depth and the write register
    localparam int WRITE_DELAY = SRAM_LATENCY + LANE_LATENCY + 1;

    pwo_mode_t                          mode;
    logic                               rd_pair_valid;
    mem_addr_t                          wr_a_addr;
    coeff_t [LANES_PER_WORD-1:0]        lane_c;
    coeff_t [LANES_PER_WORD-1:0]        lane_result;
    logic   [MEM_DATA_WIDTH-1:0]        wr_word;
    mem_word_t                          wr_data_q;

    pwo_ctrl #(
        .WRITE_DELAY (WRITE_DELAY)
    ) u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .start_i      (start_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .a_base_i     (a_base_i),
        .b_base_i     (b_base_i),
        .c_base_i     (c_base_i),
        .a_rd_en_o    (a_rd_en_o),
        .a_rd_addr_o  (a_rd_addr_o),
        .b_rd_en_o    (b_rd_en_o),
        .b_rd_addr_o  (b_rd_addr_o),
        .c_rd_en_o    (c_rd_en_o),
        .c_rd_addr_o  (c_rd_addr_o),
        .mode_o       (mode),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    //======================================================================
    // Lanes take their operands straight from the read ports
    //======================================================================

    for (genvar i = 0; i < LANES_PER_WORD; i++) begin : g_lane
        // No accumulate read means C counts as zero
        assign lane_c[i] = c_rd_valid_i ? c_rd_data_i[i][COEFF_WIDTH-1:0] : '0;

        pwo_lane u_lane (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .mode_i    (mode),
            .a_i       (a_rd_data_i[i][COEFF_WIDTH-1:0]),
            .b_i       (b_rd_data_i[i][COEFF_WIDTH-1:0]),
            .c_i       (lane_c[i]),
            .result_o  (lane_result[i])
        );
    end

    //======================================================================
    // Write alignment
    //======================================================================

    // Returns after a zeroize are dropped since busy is already low
    assign rd_pair_valid = a_rd_valid_i & b_rd_valid_i & busy_o;

    pwo_delay_line #(
        .DEPTH (WRITE_DELAY - SRAM_LATENCY),
        .T     (logic)
    ) u_wr_en_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .data_i    (rd_pair_valid),
        .data_o    (c_wr_en_o)
    );

    pwo_delay_line #(
        .DEPTH (WRITE_DELAY),
        .T     (mem_addr_t)
    ) u_wr_addr_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .data_i    (a_rd_addr_o),
        .data_o    (wr_a_addr)
    );

    // C and A addresses advance together so their difference is c_base - a_base
    assign c_wr_addr_o = wr_a_addr + (c_rd_addr_o - a_rd_addr_o);

    always_comb begin
        wr_word = '0;
        for (int i = 0; i < LANES_PER_WORD; i++) begin
            wr_word[i*LANE_WIDTH +: LANE_WIDTH] = {1'b0, lane_result[i]};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_data_q <= '0;
        end
        else if (zeroize_i) begin
            wr_data_q <= '0;
        end
        else begin
            wr_data_q <= mem_word_t'(wr_word);
        end
    end

    assign c_wr_data_o = wr_data_q;

    // Every write falls inside the operation that produced it
    assert property (@(posedge clk) disable iff (!reset_n)
        c_wr_en_o |-> busy_o)
        else $error("result write issued outside of a busy operation");

endmodule

`default_nettype wire

//--- pwo_lane/pwo_lane.sv
// Pointwise coefficient lane
`timescale 1ns/100ps
`default_nettype none

module pwo_lane
    import ntt_arith_pkg::*;
    import ntt_ctrl_pkg::*;
(
    input  wire           clk,
    input  wire           reset_n,
    input  wire           zeroize_i,

    input  var pwo_mode_t mode_i,
    input  var coeff_t    a_i,
    input  var coeff_t    b_i,
    input  var coeff_t    c_i,
    output coeff_t        result_o
);

    localparam int BYPASS_DEPTH = LANE_LATENCY - 1;

    coeff_t                product;
    coeff_t                a_d;
    coeff_t                b_d;
    coeff_t                c_d;
    coeff_t                op_x;
    coeff_t                op_y;
    logic [LANE_WIDTH-1:0] sum;
    logic [LANE_WIDTH-1:0] sum_red;
    logic [LANE_WIDTH-1:0] diff;
    coeff_t                result_q;

    pwo_mod_mult u_mod_mult (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (a_i),
        .b_i       (b_i),
        .product_o (product)
    );

    // Bypass paths match the multiplier depth so every mode has the same timing
    pwo_delay_line #(
        .DEPTH (BYPASS_DEPTH),
        .T     (coeff_t)
    ) u_a_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .data_i    (a_i),
        .data_o    (a_d)
    );

    pwo_delay_line #(
        .DEPTH (BYPASS_DEPTH),
        .T     (coeff_t)
    ) u_b_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .data_i    (b_i),
        .data_o    (b_d)
    );

    pwo_delay_line #(
        .DEPTH (BYPASS_DEPTH),
        .T     (coeff_t)
    ) u_c_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .data_i    (c_i),
        .data_o    (c_d)
    );

    //======================================================================
    // Final add or subtract mod q
    //======================================================================

    always_comb begin
        op_x    = (mode_i == pwm) ? product : a_d;
        op_y    = (mode_i == pwm) ? c_d : b_d;
        sum     = LANE_WIDTH'(op_x) + LANE_WIDTH'(op_y);
        sum_red = (sum >= NTT_Q) ? sum - NTT_Q : sum;
        // Add q back when the difference would go negative
        diff    = (op_x >= op_y) ? LANE_WIDTH'(op_x) - LANE_WIDTH'(op_y)
                                 : LANE_WIDTH'(op_x) + NTT_Q - LANE_WIDTH'(op_y);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_q <= '0;
        end
        else if (zeroize_i) begin
            result_q <= '0;
        end
        else begin
            result_q <= (mode_i == pws) ? COEFF_WIDTH'(diff) : COEFF_WIDTH'(sum_red);
        end
    end

    assign result_o = result_q;

    assert property (@(posedge clk) disable iff (!reset_n)
        !$isunknown(result_o) |-> result_o < NTT_Q)
        else $error("lane result not reduced below the modulus");

endmodule

`default_nettype wire

//--- pwo_lane/pwo_mod_mult.sv
// Pipelined Barrett modular multiplier
`timescale 1ns/100ps
`default_nettype none

module pwo_mod_mult
    import ntt_arith_pkg::*;
(
    input  wire        clk,
    input  wire        reset_n,
    input  wire        zeroize_i,

    input  var coeff_t a_i,
    input  var coeff_t b_i,
    output coeff_t     product_o
);

    localparam int PROD_WIDTH   = 2 * COEFF_WIDTH;
    localparam int SCALED_WIDTH = PROD_WIDTH + $bits(BARRETT_MU);
    localparam int QUOT_WIDTH   = SCALED_WIDTH - BARRETT_SHIFT;

    logic [PROD_WIDTH-1:0]   prod_q;
    logic [SCALED_WIDTH-1:0] scaled;
    logic [QUOT_WIDTH-1:0]   quot;
    logic [PROD_WIDTH-1:0]   rem_full;
    logic [LANE_WIDTH-1:0]   rem;
    logic [LANE_WIDTH-1:0]   reduced;
    coeff_t                  product_q;

    //======================================================================
    // Stage one holds the full 46 bit product
    //======================================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
        end
        else if (zeroize_i) begin
            prod_q <= '0;
        end
        else begin
            prod_q <= PROD_WIDTH'(a_i) * PROD_WIDTH'(b_i);
        end
    end

    //======================================================================
    // Stage two reduces mod q
    //======================================================================

    always_comb begin
        scaled   = SCALED_WIDTH'(prod_q) * SCALED_WIDTH'(BARRETT_MU);
        // Estimate is at most one below the true quotient
        quot     = scaled[SCALED_WIDTH-1:BARRETT_SHIFT];
        rem_full = prod_q - PROD_WIDTH'(quot) * PROD_WIDTH'(NTT_Q);
        // Remainder is below 2q here so 24 bits hold it
        rem      = rem_full[LANE_WIDTH-1:0];
        reduced  = (rem >= NTT_Q) ? rem - NTT_Q : rem;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            product_q <= '0;
        end
        else if (zeroize_i) begin
            product_q <= '0;
        end
        else begin
            product_q <= COEFF_WIDTH'(reduced);
        end
    end

    assign product_o = product_q;

    // Stage one only ever loads two reduced coefficients
    assert property (@(posedge clk) disable iff (!reset_n)
        !zeroize_i && !$isunknown({a_i, b_i}) |-> a_i < NTT_Q && b_i < NTT_Q)
        else $error("multiplier operand at or above the modulus");

endmodule

`default_nettype wire

//--- verification/pwo_mem_model.sv
// Testbench SRAM model
`timescale 1ns/100ps
`default_nettype none

module pwo_mem_model
    import ntt_arith_pkg::*;
    import ntt_ctrl_pkg::*;
(
    input  wire           clk,
    input  wire           reset_n,

    input  wire           rd_en_i,
    input  var mem_addr_t rd_addr_i,
    output mem_word_t     rd_data_o,
    output logic          rd_valid_o,

    input  wire           wr_en_i,
    input  var mem_addr_t wr_addr_i,
    input  var mem_word_t wr_data_i
);

    localparam int WORDS = 2 ** MEM_ADDR_WIDTH;

    // The testbench preloads and reads this array directly
    mem_word_t mem [WORDS];

    // One cycle read latency with a single cycle valid strobe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_data_o  <= '0;
            rd_valid_o <= 1'b0;
        end
        else begin
            rd_valid_o <= rd_en_i;
            if (rd_en_i) begin
                rd_data_o <= mem[rd_addr_i];
            end
        end
    end

    // Writes land at the clock edge
    always @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

//--- verification/pwo_tb.sv
// Pointwise unit testbench
`timescale 1ns/100ps
`default_nettype none

module pwo_tb
    import ntt_arith_pkg::*;
    import ntt_ctrl_pkg::*;
();

    localparam int     CLK_PERIOD    = 100;
    localparam int     RESET_CYCLES  = 5;
    localparam int     WRITE_LAT     = 5;
    localparam int     NUM_OPS       = 6;
    localparam int     OP_CYCLES     = 80;
    localparam int     MARGIN_CYCLES = 520;
    localparam int     WATCHDOG_NS   = (NUM_OPS * OP_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;
    localparam coeff_t Q_MAX         = coeff_t'(NTT_Q - 1);

    logic      clk;
    logic      reset_n;
    logic      zeroize_i;
    logic      start_i;
    pwo_mode_t mode_i;
    logic      accumulate_i;
    mem_addr_t a_base_i;
    mem_addr_t b_base_i;
    mem_addr_t c_base_i;

    logic      a_rd_en_o;
    mem_addr_t a_rd_addr_o;
    mem_word_t a_rd_data_i;
    logic      a_rd_valid_i;
    logic      b_rd_en_o;
    mem_addr_t b_rd_addr_o;
    mem_word_t b_rd_data_i;
    logic      b_rd_valid_i;
    logic      c_rd_en_o;
    mem_addr_t c_rd_addr_o;
    mem_word_t c_rd_data_i;
    logic      c_rd_valid_i;
    logic      c_wr_en_o;
    mem_addr_t c_wr_addr_o;
    mem_word_t c_wr_data_o;
    logic      busy_o;
    logic      done_o;

    // Operand images of the running operation
    coeff_t    a_img [POLY_WORDS][LANES_PER_WORD];
    coeff_t    b_img [POLY_WORDS][LANES_PER_WORD];
    coeff_t    c_old [POLY_WORDS][LANES_PER_WORD];
    pwo_mode_t cur_mode;
    logic      cur_acc;
    mem_addr_t cur_a_base;
    mem_addr_t cur_c_base;
    string     test_name;
    integer    seed;
    int        write_count;
    logic      quiet;

    always #(CLK_PERIOD / 2) clk = ~clk;

    pwo_top #(
        .SRAM_LATENCY (1)
    ) uut (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .start_i      (start_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .a_base_i     (a_base_i),
        .b_base_i     (b_base_i),
        .c_base_i     (c_base_i),
        .a_rd_en_o    (a_rd_en_o),
        .a_rd_addr_o  (a_rd_addr_o),
        .a_rd_data_i  (a_rd_data_i),
        .a_rd_valid_i (a_rd_valid_i),
        .b_rd_en_o    (b_rd_en_o),
        .b_rd_addr_o  (b_rd_addr_o),
        .b_rd_data_i  (b_rd_data_i),
        .b_rd_valid_i (b_rd_valid_i),
        .c_rd_en_o    (c_rd_en_o),
        .c_rd_addr_o  (c_rd_addr_o),
        .c_rd_data_i  (c_rd_data_i),
        .c_rd_valid_i (c_rd_valid_i),
        .c_wr_en_o    (c_wr_en_o),
        .c_wr_addr_o  (c_wr_addr_o),
        .c_wr_data_o  (c_wr_data_o),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    pwo_mem_model u_mem_a (
        .clk (clk), .reset_n (reset_n),
        .rd_en_i (a_rd_en_o), .rd_addr_i (a_rd_addr_o),
        .rd_data_o (a_rd_data_i), .rd_valid_o (a_rd_valid_i),
        .wr_en_i (1'b0), .wr_addr_i ('0), .wr_data_i ('0)
    );

    pwo_mem_model u_mem_b (
        .clk (clk), .reset_n (reset_n),
        .rd_en_i (b_rd_en_o), .rd_addr_i (b_rd_addr_o),
        .rd_data_o (b_rd_data_i), .rd_valid_o (b_rd_valid_i),
        .wr_en_i (1'b0), .wr_addr_i ('0), .wr_data_i ('0)
    );

    pwo_mem_model u_mem_c (
        .clk (clk), .reset_n (reset_n),
        .rd_en_i (c_rd_en_o), .rd_addr_i (c_rd_addr_o),
        .rd_data_o (c_rd_data_i), .rd_valid_o (c_rd_valid_i),
        .wr_en_i (c_wr_en_o), .wr_addr_i (c_wr_addr_o), .wr_data_i (c_wr_data_o)
    );

    //======================================================================
    // Failure reporting
    //======================================================================

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(string test, mem_word_t expected, mem_word_t actual);
        $display("FAIL %s expected %h actual %h", test, expected, actual);
        abort_run();
    endtask

    task automatic note_failure(string what);
        $display("ERROR in %s: %s", test_name, what);
        abort_run();
    endtask

    //======================================================================
    // Behavioral mod q model
    //======================================================================

    function automatic coeff_t expected_lane(pwo_mode_t mode, logic acc,
                                             coeff_t a, coeff_t b, coeff_t c);
        longint q;
        longint r;
        q = longint'(NTT_Q);
        case (mode)
            pwm:     r = (longint'(a) * longint'(b) + (acc ? longint'(c) : longint'(0))) % q;
            pwa:     r = (longint'(a) + longint'(b)) % q;
            default: r = (longint'(a) - longint'(b) + q) % q;
        endcase
        return coeff_t'(r);
    endfunction

    // Offsets past the polynomial give set top bits that no write can match
    function automatic mem_word_t expected_word(mem_addr_t offset);
        mem_word_t word;
        word = '1;
        if (offset < POLY_WORDS) begin
            for (int l = 0; l < LANES_PER_WORD; l++) begin
                word[l] = {1'b0, expected_lane(cur_mode, cur_acc, a_img[offset][l],
                                               b_img[offset][l], c_old[offset][l])};
            end
        end
        return word;
    endfunction

    function automatic coeff_t random_coeff();
        return coeff_t'($unsigned($random(seed)) % NTT_Q);
    endfunction

    //======================================================================
    // Protocol tracking and checks
    //======================================================================

    // Quiet from reset or zeroize until the next accepted start
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            quiet       <= 1'b1;
            write_count <= 0;
        end
        else begin
            if (zeroize_i) begin
                quiet <= 1'b1;
            end
            else if (start_i && !busy_o) begin
                quiet <= 1'b0;
            end
            if (start_i && !busy_o) begin
                write_count <= 0;
            end
            else if (c_wr_en_o) begin
                write_count <= write_count + 1;
            end
        end
    end

    idle_outputs_low: assert property (@(posedge clk) disable iff (!reset_n)
        quiet |-> !(busy_o || done_o || a_rd_en_o || b_rd_en_o || c_rd_en_o || c_wr_en_o))
        else note_failure("an enable, busy or done was high before the next start");

    write_data_matches: assert property (@(posedge clk) disable iff (!reset_n)
        c_wr_en_o |-> c_wr_data_o == expected_word(c_wr_addr_o - cur_c_base))
        else report_mismatch(test_name,
                             expected_word($sampled(c_wr_addr_o) - $sampled(cur_c_base)),
                             $sampled(c_wr_data_o));

    write_follows_read: assert property (@(posedge clk) disable iff (!reset_n)
        c_wr_en_o |-> $past(a_rd_en_o, WRITE_LAT) &&
            c_wr_addr_o == mem_addr_t'($past(a_rd_addr_o, WRITE_LAT) - cur_a_base + cur_c_base))
        else note_failure("a write did not follow its A read by five cycles at the same offset");

    read_gets_write: assert property (@(posedge clk) disable iff (!reset_n)
        a_rd_en_o |-> ##WRITE_LAT (c_wr_en_o || quiet))
        else note_failure("an A read was not followed by a write five cycles later");

    c_read_only_acc: assert property (@(posedge clk) disable iff (!reset_n)
        (a_rd_en_o || c_rd_en_o) |-> c_rd_en_o == (a_rd_en_o && cur_mode == pwm && cur_acc))
        else note_failure("C read enable did not match pwm with accumulate");

    done_after_last_write: assert property (@(posedge clk) disable iff (!reset_n)
        done_o |-> write_count == POLY_WORDS && $past(c_wr_en_o) && !c_wr_en_o &&
            !busy_o && $past(busy_o))
        else note_failure("done was not on the cycle after the 64th write with busy falling");

    done_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        done_o |=> !done_o)
        else note_failure("done stayed high for more than one cycle");

    busy_falls_cleanly: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(busy_o) |-> done_o || quiet)
        else note_failure("busy fell without done or zeroize");

    //======================================================================
    // Stimulus
    //======================================================================

    task automatic load_operands(mem_addr_t a_base, mem_addr_t b_base, mem_addr_t c_base);
        mem_word_t a_word;
        mem_word_t b_word;
        mem_word_t c_word;
        for (int i = 0; i < POLY_WORDS; i++) begin
            for (int l = 0; l < LANES_PER_WORD; l++) begin
                a_img[i][l] = random_coeff();
                b_img[i][l] = random_coeff();
                c_old[i][l] = random_coeff();
                // Corner pairs of 0 and q-1 on the diagonal of the first words
                if (i == l) begin
                    a_img[i][l] = i[0] ? Q_MAX : '0;
                    b_img[i][l] = i[1] ? Q_MAX : '0;
                    c_old[i][l] = Q_MAX;
                end
                a_word[l] = {1'b0, a_img[i][l]};
                b_word[l] = {1'b0, b_img[i][l]};
                c_word[l] = {1'b0, c_old[i][l]};
            end
            u_mem_a.mem[mem_addr_t'(a_base + i)] = a_word;
            u_mem_b.mem[mem_addr_t'(b_base + i)] = b_word;
            u_mem_c.mem[mem_addr_t'(c_base + i)] = c_word;
        end
    endtask

    task automatic start_op(pwo_mode_t mode, logic acc, mem_addr_t a_base,
                            mem_addr_t b_base, mem_addr_t c_base);
        @(posedge clk);
        start_i      <= 1'b1;
        mode_i       <= mode;
        accumulate_i <= acc;
        a_base_i     <= a_base;
        b_base_i     <= b_base;
        c_base_i     <= c_base;
        cur_mode     <= mode;
        cur_acc      <= acc;
        cur_a_base   <= a_base;
        cur_c_base   <= c_base;
        @(posedge clk);
        start_i <= 1'b0;
    endtask

    task automatic check_memory(mem_addr_t c_base);
        mem_word_t expected;
        mem_word_t actual;
        for (int i = 0; i < POLY_WORDS; i++) begin
            expected = expected_word(mem_addr_t'(i));
            actual   = u_mem_c.mem[mem_addr_t'(c_base + i)];
            assert (actual == expected)
                else report_mismatch($sformatf("%s word %0d", test_name, i), expected, actual);
        end
    endtask

    task automatic run_op(string name, pwo_mode_t mode, logic acc, mem_addr_t a_base,
                          mem_addr_t b_base, mem_addr_t c_base, logic restart_mid);
        int cycles;
        test_name = name;
        load_operands(a_base, b_base, c_base);
        start_op(mode, acc, a_base, b_base, c_base);
        if (restart_mid) begin
            repeat (10) @(posedge clk);
            // Start while busy must leave the running operation alone
            start_i <= 1'b1;
            mode_i  <= pws;
            @(posedge clk);
            start_i <= 1'b0;
        end
        cycles = 0;
        while (!done_o && cycles < OP_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (!done_o) begin
            note_failure("timed out waiting for done_o");
        end
        check_memory(c_base);
    endtask

    task automatic zeroize_op(string name, pwo_mode_t mode, mem_addr_t a_base,
                              mem_addr_t b_base, mem_addr_t c_base);
        test_name = name;
        load_operands(a_base, b_base, c_base);
        start_op(mode, 1'b0, a_base, b_base, c_base);
        repeat (20) @(posedge clk);
        zeroize_i <= 1'b1;
        @(posedge clk);
        zeroize_i <= 1'b0;
        // Give the idle check time to watch the cleared unit
        repeat (2 * WRITE_LAT) @(posedge clk);
    endtask

    initial begin
        clk          = 1'b0;
        reset_n      = 1'b0;
        zeroize_i    = 1'b0;
        start_i      = 1'b0;
        mode_i       = pwm;
        accumulate_i = 1'b0;
        a_base_i     = '0;
        b_base_i     = '0;
        c_base_i     = '0;
        cur_mode     = pwm;
        cur_acc      = 1'b0;
        cur_a_base   = '0;
        cur_c_base   = '0;
        test_name    = "reset";
        seed         = 22926;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        repeat (5) @(posedge clk);

        run_op("pwm", pwm, 1'b0, 15'h0000, 15'h0100, 15'h0200, 1'b1);
        run_op("pwm_acc", pwm, 1'b1, 15'h0400, 15'h0500, 15'h0600, 1'b0);
        run_op("pwa", pwa, 1'b0, 15'h1000, 15'h2000, 15'h3000, 1'b0);
        run_op("pws", pws, 1'b0, 15'h1040, 15'h2040, 15'h3040, 1'b0);
        zeroize_op("zeroize", pwa, 15'h0800, 15'h0900, 15'h0A00);
        // C region wraps past the top of the address space
        run_op("pwm_acc_wrap", pwm, 1'b1, 15'h4000, 15'h5000, 15'h7FE0, 1'b0);

        $display("TESTBENCH PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        note_failure("watchdog expired before the operations finished");
    end

endmodule

`default_nettype wire
